// ==== include/fifo_tree_defines.svh ====
// Widths are fixed here for the whole gather stage. FT_LANE_BITS must stay equal to clog2 of FT_NUM_LANES
`ifndef FIFO_TREE_DEFINES_SVH
`define FIFO_TREE_DEFINES_SVH

// Data word carried by every leaf lane
`define FT_WORD_WIDTH 36

// Leaf lanes feeding this gather stage
`define FT_NUM_LANES 5

// Lane index width
// Kept by hand in step with FT_NUM_LANES
// Also wide enough for a batch count up to FT_NUM_LANES when the
// lane count is not a power of two
`define FT_LANE_BITS 3

// Flattened bus width for all lanes together
// Lane k sits at bits k*FT_WORD_WIDTH upward
`define FT_FLAT_WIDTH (`FT_NUM_LANES * `FT_WORD_WIDTH)

`endif

// ==== verilog/fifo_tree_pkg.sv ====
// Shared types for the gather stage. The lane index width comes from the defines header
`default_nettype none

`include "fifo_tree_defines.svh"

package fifo_tree_pkg;

    // Lane number carried as the tag on each output word
    typedef logic [`FT_LANE_BITS-1:0] lane_idx_t;

    // Serializer control states
    // SER_IDLE waits for a snapshot from the lane buffer
    // SER_EMIT drains the packed batch one word per cycle
    typedef enum logic {
        SER_IDLE = 1'b0,   // No batch held
        SER_EMIT = 1'b1    // Batch words remain
    } ser_state_t;

endpackage

`default_nettype wire

// ==== verilog/lane_buffer.sv ====
// Holds one word per lane. A write to an occupied lane is dropped unless that lane is snapped in the same cycle
`timescale 1ns/1ns
`default_nettype none

`include "fifo_tree_defines.svh"

module lane_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`FT_NUM_LANES-1:0]    lane_wr_i,    // Write strobe per lane
    input  logic [`FT_FLAT_WIDTH-1:0]   lane_data_i,  // Lane k in slice k
    input  logic                        busy_i,       // Serializer still draining
    output logic                        snap_o,       // Handover pulse
    output logic [`FT_NUM_LANES-1:0]    snap_mask_o,  // Lanes holding a word
    output logic [`FT_FLAT_WIDTH-1:0]   snap_data_o,  // Words of the handover
    output logic                        overflow_o    // Dropped write, one cycle late
);

    logic [`FT_WORD_WIDTH-1:0] hold_q [`FT_NUM_LANES];  // Pending words
    logic [`FT_NUM_LANES-1:0]  pend_q;                 // Pending flags
    logic                      snap_take;              // Handover at this edge
    logic [`FT_NUM_LANES-1:0]  wr_accept;              // Writes that land
    logic [`FT_NUM_LANES-1:0]  wr_drop;                // Writes that are lost

    // Serializer idle and no handover already in flight.
    // busy_i only rises one edge after snap_o, so snap_o blocks that gap
    assign snap_take = (|pend_q) && !busy_i && !snap_o;

    // Empty lane, or its old word leaves with this snapshot
    assign wr_accept = lane_wr_i & (~pend_q | {`FT_NUM_LANES{snap_take}});
    assign wr_drop   = lane_wr_i & ~wr_accept;

    // Pending flags
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q <= '0;                      // All lanes empty
        end else if (snap_take) begin
            pend_q <= wr_accept;               // Only writes of the snap cycle remain
        end else begin
            pend_q <= pend_q | wr_accept;
        end
    end

    // Word storage per lane
    always_ff @(posedge clk) begin
        for (int k = 0; k < `FT_NUM_LANES; k++) begin
            if (wr_accept[k]) begin
                hold_q[k] <= lane_data_i[k*`FT_WORD_WIDTH +: `FT_WORD_WIDTH];
            end
        end
    end

    // Handover strobe, mask and overflow flag
    always_ff @(posedge clk) begin
        if (reset) begin
            snap_o      <= 1'b0;
            snap_mask_o <= '0;
            overflow_o  <= 1'b0;
        end else begin
            snap_o     <= snap_take;
            overflow_o <= |wr_drop;            // Several drops in one cycle give one pulse
            if (snap_take) begin
                snap_mask_o <= pend_q;         // Old flags, before this cycle's writes
            end
        end
    end

    // Snapshot words
    // Taken from the holding registers before any write of the same edge
    always_ff @(posedge clk) begin
        if (snap_take) begin
            for (int k = 0; k < `FT_NUM_LANES; k++) begin
                snap_data_o[k*`FT_WORD_WIDTH +: `FT_WORD_WIDTH] <= hold_q[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/word_serializer.sv ====
// Emits only the valid words of a snapshot in ascending lane order. There is no back-pressure and a snap while busy is ignored
`timescale 1ns/1ns
`default_nettype none

`include "fifo_tree_defines.svh"

module word_serializer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          snap_i,       // Handover pulse
    input  logic [`FT_NUM_LANES-1:0]      snap_mask_i,  // Lanes with a word
    input  logic [`FT_FLAT_WIDTH-1:0]     snap_data_i,  // Lane k in slice k
    output logic                          busy_o,       // Batch words remain
    output logic [`FT_WORD_WIDTH-1:0]     out_data_o,
    output fifo_tree_pkg::lane_idx_t      out_lane_o,   // Source lane of out_data_o
    output logic                          out_valid_o   // Level, one cycle per word
);

    // Count needs one more code than the index to reach FT_NUM_LANES
    logic [`FT_LANE_BITS:0]    pack_cnt;                    // Valid words in snapshot
    logic [`FT_WORD_WIDTH-1:0] pack_data [`FT_NUM_LANES];   // Compacted words
    fifo_tree_pkg::lane_idx_t  pack_lane [`FT_NUM_LANES];   // Their lane tags

    logic [`FT_WORD_WIDTH-1:0] buf_data_q [`FT_NUM_LANES];  // Batch held for emission
    fifo_tree_pkg::lane_idx_t  buf_lane_q [`FT_NUM_LANES];
    logic [`FT_LANE_BITS:0]    cnt_q;                       // Words in current batch
    logic [`FT_LANE_BITS:0]    rd_idx_q;                    // Next slot to emit
    logic                      load;                        // Accept a snapshot
    logic                      last_word;                   // Final slot this cycle
    fifo_tree_pkg::ser_state_t state_q;

    // Compaction of masked lanes into the low slots
    always_comb begin
        pack_cnt = '0;
        for (int k = 0; k < `FT_NUM_LANES; k++) begin
            pack_data[k] = '0;                               // Unused slots stay zero
            pack_lane[k] = '0;
        end
        for (int k = 0; k < `FT_NUM_LANES; k++) begin
            if (snap_mask_i[k]) begin
                pack_data[pack_cnt[`FT_LANE_BITS-1:0]] =
                    snap_data_i[k*`FT_WORD_WIDTH +: `FT_WORD_WIDTH];
                pack_lane[pack_cnt[`FT_LANE_BITS-1:0]] = fifo_tree_pkg::lane_idx_t'(k);
                pack_cnt = pack_cnt + 1'b1;
            end
        end
    end

    assign load      = snap_i && (state_q == fifo_tree_pkg::SER_IDLE) && (pack_cnt != '0);
    assign last_word = (rd_idx_q + 1'b1) == cnt_q;

    // High from the snap edge until the edge of the last word
    assign busy_o = (state_q == fifo_tree_pkg::SER_EMIT);

    // FSM and read pointer
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= fifo_tree_pkg::SER_IDLE;
            cnt_q       <= '0;
            rd_idx_q    <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= 1'b0;                             // Default no word
            case (state_q)
                fifo_tree_pkg::SER_IDLE: begin
                    if (load) begin
                        cnt_q    <= pack_cnt;
                        rd_idx_q <= '0;
                        state_q  <= fifo_tree_pkg::SER_EMIT;
                    end
                end
                fifo_tree_pkg::SER_EMIT: begin
                    out_valid_o <= 1'b1;
                    rd_idx_q    <= rd_idx_q + 1'b1;
                    if (last_word) begin
                        state_q <= fifo_tree_pkg::SER_IDLE;  // Stop at the word count
                    end
                end
                default: state_q <= fifo_tree_pkg::SER_IDLE;
            endcase
        end
    end

    // Batch buffer, only loaded from idle
    always_ff @(posedge clk) begin
        if (load) begin
            for (int k = 0; k < `FT_NUM_LANES; k++) begin
                buf_data_q[k] <= pack_data[k];
                buf_lane_q[k] <= pack_lane[k];
            end
        end
    end

    // Output word and tag
    always_ff @(posedge clk) begin
        if (state_q == fifo_tree_pkg::SER_EMIT) begin
            out_data_o <= buf_data_q[rd_idx_q[`FT_LANE_BITS-1:0]];
            out_lane_o <= buf_lane_q[rd_idx_q[`FT_LANE_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fifo_tree_gather.sv ====
// Gather stage of the FIFO tree. Output words must be taken when valid since there is no back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "fifo_tree_defines.svh"

module fifo_tree_gather (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`FT_NUM_LANES-1:0]      lane_wr_i,    // Write strobe per leaf lane
    input  logic [`FT_FLAT_WIDTH-1:0]     lane_data_i,  // Flattened lane words
    output logic [`FT_WORD_WIDTH-1:0]     out_data_o,   // Serialized word
    output fifo_tree_pkg::lane_idx_t      out_lane_o,   // Lane tag
    output logic                          out_valid_o,
    output logic                          overflow_o    // Dropped lane write
);

    // Handover between lane buffer and serializer
    logic                       snap;
    logic [`FT_NUM_LANES-1:0]   snap_mask;
    logic [`FT_FLAT_WIDTH-1:0]  snap_data;
    logic                       busy;      // Serializer draining a batch

    // Leaf side holding registers
    lane_buffer lane_buffer_i (
        .clk         (clk),
        .reset       (reset),
        .lane_wr_i   (lane_wr_i),
        .lane_data_i (lane_data_i),
        .busy_i      (busy),
        .snap_o      (snap),
        .snap_mask_o (snap_mask),
        .snap_data_o (snap_data),
        .overflow_o  (overflow_o)
    );

    // Packs and emits one batch at a time
    word_serializer word_serializer_i (
        .clk         (clk),
        .reset       (reset),
        .snap_i      (snap),
        .snap_mask_i (snap_mask),
        .snap_data_i (snap_data),
        .busy_o      (busy),
        .out_data_o  (out_data_o),
        .out_lane_o  (out_lane_o),
        .out_valid_o (out_valid_o)
    );

endmodule

`default_nettype wire

// ==== verif/tb_fifo_tree_gather.sv ====
// Drops are expected from the table's drop column, and output words are taken on every valid cycle
`timescale 1ns/1ns
`default_nettype none

`include "fifo_tree_defines.svh"

module tb_fifo_tree_gather;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int ROW_MARGIN   = 20;   // Watchdog slack per row
    localparam int DRAIN_LIMIT  = 40;   // Cycles allowed to empty the model
    localparam int RAND_ROWS    = 8;

    logic                        clk = 1'b0;
    logic                        reset;
    logic [`FT_NUM_LANES-1:0]    lane_wr;
    logic [`FT_FLAT_WIDTH-1:0]   lane_data;
    logic [`FT_WORD_WIDTH-1:0]   out_data;
    fifo_tree_pkg::lane_idx_t    out_lane;
    logic                        out_valid;
    logic                        overflow;

    // Stimulus table, one entry per row
    string                     row_name [$];
    logic [`FT_NUM_LANES-1:0]  row_mask [$];   // Lanes written
    logic [`FT_NUM_LANES-1:0]  row_drop [$];   // Writes expected to be lost
    int                        row_idle [$];   // Idle cycles after the write

    // Reference model, one queue per lane
    logic [`FT_WORD_WIDTH-1:0] exp_q [`FT_NUM_LANES][$];
    int                        exp_row_q [`FT_NUM_LANES][$];  // Row that wrote each word

    logic [31:0] rng_state    = 32'h5ec64e45;
    logic        table_ready  = 1'b0;
    logic        ovf_expected = 1'b0;   // From the previous cycle's drive
    logic        prev_valid   = 1'b0;
    int          prev_lane    = 0;
    int          err_cnt      = 0;
    int          word_cnt     = 0;
    int          ovf_cnt      = 0;
    int          run_cnt      = 0;      // Unbroken stretches of out_valid_o

    fifo_tree_gather dut_i (
        .clk         (clk),
        .reset       (reset),
        .lane_wr_i   (lane_wr),
        .lane_data_i (lane_data),
        .out_data_o  (out_data),
        .out_lane_o  (out_lane),
        .out_valid_o (out_valid),
        .overflow_o  (overflow)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Xorshift generator
    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [`FT_WORD_WIDTH-1:0] random_word();
        logic [63:0] both;
        both[63:32] = next_random();
        both[31:0]  = next_random();
        return both[`FT_WORD_WIDTH-1:0];   // Upper bits dropped
    endfunction

    task automatic add_row(input string name, input logic [`FT_NUM_LANES-1:0] mask,
                           input logic [`FT_NUM_LANES-1:0] drop, input int idle);
        row_name.push_back(name);
        row_mask.push_back(mask);
        row_drop.push_back(drop);
        row_idle.push_back(idle);
    endtask

    task automatic load_table();
        logic [31:0]              r;
        logic [`FT_NUM_LANES-1:0] mask;
        add_row("reset_idle", '0, '0, 4);           // Nothing written, nothing out
        add_row("single_l0", 5'h01, '0, 8);
        add_row("single_l3", 5'h08, '0, 8);
        add_row("pack_0_2_4", 5'h15, '0, 8);
        add_row("pack_1_3", 5'h0a, '0, 8);
        add_row("pack_all", 5'h1f, '0, 8);
        // Second write lands in the snap cycle and must be kept
        add_row("snap_cycle_first", 5'h02, '0, 0);
        add_row("snap_cycle_rewrite", 5'h02, '0, 10);
        for (int i = 0; i < RAND_ROWS; i++) begin
            r    = next_random();
            mask = r[`FT_NUM_LANES-1:0];
            if (mask == '0) begin
                mask = 5'h01;
            end
            add_row("rand_order", mask, '0, 8);     // Spacing keeps every lane clear
        end
        // Serializer busy with five words, lane 0 pending when hit again
        add_row("ovf_full", 5'h1f, '0, 1);
        add_row("ovf_lane0", 5'h01, '0, 0);
        add_row("ovf_drop", 5'h01, 5'h01, 10);
    endtask

    function automatic bit queues_empty();
        for (int k = 0; k < `FT_NUM_LANES; k++) begin
            if (exp_q[k].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Outputs sampled at the falling edge, half a cycle after they change
    task automatic check_outputs(input int row);
        int                        lane;
        int                        src_row;
        logic [`FT_WORD_WIDTH-1:0] exp_word;
        if (overflow !== ovf_expected) begin
            $display("ERR %s: overflow_o expected %b, got %b",
                     row_name[row], ovf_expected, overflow);
            err_cnt++;
        end
        if (overflow === 1'b1) begin
            ovf_cnt++;
        end
        if (out_valid === 1'b1) begin
            lane = int'(out_lane);
            if (!prev_valid) begin
                run_cnt++;
            end
            if (prev_valid && lane <= prev_lane) begin       // Within one batch
                $display("ERR %s: lane tag expected above %0d, got %0d",
                         row_name[row], prev_lane, lane);
                err_cnt++;
            end
            if (lane >= `FT_NUM_LANES) begin
                $display("Output word carries lane tag %0d, which is not a lane", lane);
                err_cnt++;
            end else if (exp_q[lane].size() == 0) begin
                $display("Word %h came out for lane %0d, but nothing was written there",
                         out_data, lane);
                err_cnt++;
            end else begin
                exp_word = exp_q[lane].pop_front();
                src_row  = exp_row_q[lane].pop_front();
                word_cnt++;
                if (out_data !== exp_word) begin
                    $display("ERR %s: lane %0d word expected %h, got %h",
                             row_name[src_row], lane, exp_word, out_data);
                    err_cnt++;
                end
            end
            prev_lane  = lane;
            prev_valid = 1'b1;
        end else begin
            if (out_valid !== 1'b0) begin
                $display("out_valid_o is unknown during %s", row_name[row]);
                err_cnt++;
            end
            prev_valid = 1'b0;
        end
    endtask

    // One clock cycle: check, then drive on the falling edge
    task automatic run_cycle(input logic [`FT_NUM_LANES-1:0] mask,
                             input logic [`FT_NUM_LANES-1:0] drop, input int row);
        logic [`FT_WORD_WIDTH-1:0] word;
        @(negedge clk);
        check_outputs(row);
        lane_wr = mask;
        for (int k = 0; k < `FT_NUM_LANES; k++) begin
            word = random_word();                            // Idle lanes carry noise too
            lane_data[k*`FT_WORD_WIDTH +: `FT_WORD_WIDTH] = word;
            if (mask[k] && !drop[k]) begin
                exp_q[k].push_back(word);
                exp_row_q[k].push_back(row);
            end
        end
        ovf_expected = |drop;    // Pulse due in the next cycle
    endtask

    initial begin : stimulus
        int drain;
        int last;
        bit start_empty;
        int runs_before;
        int exp_runs;
        reset     = 1'b1;
        lane_wr   = '0;
        lane_data = '0;
        load_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) run_cycle('0, '0, 0);
        reset = 1'b0;
        for (int r = 0; r < row_name.size(); r++) begin
            start_empty = queues_empty();
            runs_before = run_cnt;
            run_cycle(row_mask[r], row_drop[r], r);
            repeat (row_idle[r]) run_cycle('0, '0, r);
            // One write into an empty buffer is one snapshot, so one unbroken run
            exp_runs = (row_mask[r] != '0) ? 1 : 0;
            if (start_empty && queues_empty() && (run_cnt - runs_before) != exp_runs) begin
                $display("ERR %s: output runs expected %0d, got %0d",
                         row_name[r], exp_runs, run_cnt - runs_before);
                err_cnt++;
            end
        end
        last  = row_name.size() - 1;
        drain = 0;
        while (!queues_empty() && drain < DRAIN_LIMIT) begin
            run_cycle('0, '0, last);
            drain++;
        end
        repeat (4) run_cycle('0, '0, last);                  // Catch stray words
        if (!queues_empty()) begin
            $display("Words written to the lanes were never emitted");
            err_cnt++;
        end
        $display("Summary: %0d errors, %0d words checked, %0d overflow pulses",
                 err_cnt, word_cnt, ovf_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Limit from the table length
    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = RESET_CYCLES;
        for (int r = 0; r < row_name.size(); r++) begin
            limit += 1 + row_idle[r] + ROW_MARGIN;
        end
        #(limit * CLK_PERIOD);
        $display("Timeout: run did not end within %0d cycles", limit);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
verilog/fifo_tree_pkg.sv
verilog/lane_buffer.sv
verilog/word_serializer.sv
verilog/fifo_tree_gather.sv
verif/tb_fifo_tree_gather.sv

// ==== Makefile ====
# Verilator flow for the FIFO tree gather stage

VERILATOR  ?= verilator
TB_TOP     ?= tb_fifo_tree_gather
RTL_TOP    ?= fifo_tree_gather
FILE_LIST  ?= sources.f
INC_DIR    ?= include
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= All tests passed

RTL_SRCS   ?= verilog/fifo_tree_pkg.sv \
              verilog/lane_buffer.sv \
              verilog/word_serializer.sv \
              verilog/fifo_tree_gather.sv

LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) +incdir+$(INC_DIR) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
